// ==== source/bus_map_pkg.sv ====
// Bus widths, slave select field and control register map for the slave-0 logic
`default_nettype none

package bus_map_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Bus geometry
   localparam int DATA_W    = 16;
   localparam int ADDR_W    = 11;
   localparam int SLAVE_LSB = 7;        // Slave index sits in adr[10:7]
   localparam int SLAVE_W   = 4;
   localparam logic [SLAVE_W-1:0] CTRL_SLAVE = 4'd0;

   ////////////////////////////////////////////////////////////////////////////
   // Slave 0 register offsets, even byte addresses
   typedef enum logic [6:0] {
      REG_LEDS        = 7'd0,   // rw
      REG_SWITCHES    = 7'd2,   // ro
      REG_CGEN_CTRL   = 7'd4,   // rw
      REG_CGEN_ST     = 7'd6,   // ro
      REG_TEST        = 7'd8,   // rw
      REG_RX_FRAMELEN = 7'd10,  // ro
      REG_TX_FRAMELEN = 7'd12,  // wo
      REG_XFER_RATE   = 7'd14   // wo
   } reg_off_e;

   localparam logic [15:0] READ_FILLER     = 16'hBEEF;
   localparam logic [1:0]  CGEN_CTRL_RESET = 2'b11;   // Sync deasserted, ref sel high
   localparam int TX_EN_BIT = 15;
   localparam int RX_EN_BIT = 14;

endpackage

`default_nettype wire

// ==== source/ctrl_core_top.sv ====
// Control core top, joins the slave 0 decoder, register bank, read mux and the TX and RX pacers
`timescale 1ns/1ps
`default_nettype none

module ctrl_core_top
#(
   parameter int DATA_W = bus_map_pkg::DATA_W,
   parameter int ADDR_W = bus_map_pkg::ADDR_W,
   parameter int RATE_W = ctrl_kind_pkg::RATE_W
)
(
   input  wire logic              wb_clk,
   input  wire logic              wb_rst,
   // Wishbone, single master
   input  wire logic              wb_cyc_i,
   input  wire logic              wb_stb_i,
   input  wire logic              wb_we_i,
   input  wire logic [ADDR_W-1:0] wb_adr_i,
   input  wire logic [DATA_W-1:0] wb_dat_i,
   output logic [DATA_W-1:0]      wb_dat_o,
   output logic                   wb_ack_o,
   // Board
   output logic [2:0]             led_o,
   output logic                   cgen_sync_b_o,
   output logic                   cgen_ref_sel_o,
   input  wire logic [7:0]        dip_sw_i,
   input  wire logic [2:0]        push_btn_i,
   input  wire logic              cgen_st_status_i,
   input  wire logic              cgen_st_ld_i,
   input  wire logic              cgen_st_refmon_i,
   input  wire logic [DATA_W-1:0] rx_frame_len_i,
   output logic [DATA_W-1:0]      tx_frame_len_o,
   // TX handshake
   input  wire logic              tx_src_rdy_i,
   output logic                   tx_dst_rdy_o,
   output logic                   tx_src_rdy_o,
   input  wire logic              tx_dst_rdy_i,
   output logic                   tx_underrun_o,
   // RX handshake
   input  wire logic              rx_src_rdy_i,
   output logic                   rx_dst_rdy_o,
   output logic                   rx_src_rdy_o,
   input  wire logic              rx_dst_rdy_i,
   output logic                   rx_overrun_o
);

   ctrl_kind_pkg::access_e acc_kind;
   logic                   ctrl_hit;
   bus_map_pkg::reg_off_e  reg_off;
   logic [DATA_W-1:0]      leds_reg, cgen_reg, test_reg;
   logic [RATE_W-1:0]      rate;
   logic                   tx_en, rx_en;

   ////////////////////////////////////////////////////////////////////////////
   // Slave 0
   wb_slave_decode #(.ADDR_W(ADDR_W)) decode
     (.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
      .acc_kind_o(acc_kind), .ctrl_hit_o(ctrl_hit), .reg_off_o(reg_off));

   ctrl_reg_bank #(.DATA_W(DATA_W), .RATE_W(RATE_W)) bank
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .acc_kind_i(acc_kind), .ctrl_hit_i(ctrl_hit), .reg_off_i(reg_off), .wr_dat_i(wb_dat_i),
      .leds_reg_o(leds_reg), .cgen_reg_o(cgen_reg), .test_reg_o(test_reg),
      .tx_frame_len_o(tx_frame_len_o), .rate_o(rate), .tx_en_o(tx_en), .rx_en_o(rx_en),
      .led_o(led_o), .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   read_result_mux #(.DATA_W(DATA_W)) result
     (.acc_kind_i(acc_kind), .ctrl_hit_i(ctrl_hit), .reg_off_i(reg_off),
      .leds_reg_i(leds_reg), .cgen_reg_i(cgen_reg), .test_reg_i(test_reg),
      .dip_sw_i(dip_sw_i), .push_btn_i(push_btn_i),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .rx_frame_len_i(rx_frame_len_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o));

   ////////////////////////////////////////////////////////////////////////////
   // Pacers, shared rate, separate enables
   xfer_pacer #(.RATE_W(RATE_W)) tx_pacer
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .enable_i(tx_en), .rate_i(rate),
      .up_rdy_i(tx_src_rdy_i), .up_take_o(tx_dst_rdy_o),
      .dn_rdy_o(tx_src_rdy_o), .dn_take_i(tx_dst_rdy_i),
      .slip_o(tx_underrun_o));

   xfer_pacer #(.RATE_W(RATE_W)) rx_pacer
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .enable_i(rx_en), .rate_i(rate),
      .up_rdy_i(rx_src_rdy_i), .up_take_o(rx_dst_rdy_o),
      .dn_rdy_o(rx_src_rdy_o), .dn_take_i(rx_dst_rdy_i),
      .slip_o(rx_overrun_o));   // Sink not taking shows up here

endmodule

`default_nettype wire

// ==== source/ctrl_kind_pkg.sv ====
// Access kinds and pacer states shared by the decoder, register bank and pacers
`default_nettype none

package ctrl_kind_pkg;

   // Kind of the current bus cycle
   typedef enum logic [1:0] {
      ACC_IDLE,
      ACC_READ,
      ACC_WRITE
   } access_e;

   // Pacer slot machine
   typedef enum logic [1:0] {
      PACE_OFF,    // Disabled
      PACE_WAIT,   // Counting down to next slot
      PACE_HOLD    // Slot granted, not yet used
   } pacer_state_e;

   localparam int RATE_W = 8;   // Low byte of the rate register

endpackage

`default_nettype wire

// ==== source/ctrl_reg_bank.sv ====
// Slave 0 writable registers, drives LEDs, clock generator lines, frame length and pacer rate
`timescale 1ns/1ps
`default_nettype none

module ctrl_reg_bank
#(
   parameter int DATA_W = bus_map_pkg::DATA_W,
   parameter int RATE_W = ctrl_kind_pkg::RATE_W
)
(
   input  wire logic                   wb_clk,
   input  wire logic                   wb_rst,
   input  wire ctrl_kind_pkg::access_e acc_kind_i,
   input  wire logic                   ctrl_hit_i,
   input  wire bus_map_pkg::reg_off_e  reg_off_i,
   input  wire logic [DATA_W-1:0]      wr_dat_i,
   output logic [DATA_W-1:0]           leds_reg_o,
   output logic [DATA_W-1:0]           cgen_reg_o,
   output logic [DATA_W-1:0]           test_reg_o,
   output logic [DATA_W-1:0]           tx_frame_len_o,
   output logic [RATE_W-1:0]           rate_o,
   output logic                        tx_en_o,
   output logic                        rx_en_o,
   output logic [2:0]                  led_o,
   output logic                        cgen_sync_b_o,
   output logic                        cgen_ref_sel_o
);

   logic wr_en;

   assign wr_en = ctrl_hit_i && (acc_kind_i == ctrl_kind_pkg::ACC_WRITE);

   ////////////////////////////////////////////////////////////////////////////
   // Register writes
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         leds_reg_o     <= '0;
         cgen_reg_o     <= DATA_W'(bus_map_pkg::CGEN_CTRL_RESET);
         test_reg_o     <= '0;
         tx_frame_len_o <= '0;
         rate_o         <= '0;
         tx_en_o        <= 1'b0;
         rx_en_o        <= 1'b0;
      end
      else if (wr_en)
      begin
         case (reg_off_i)
            bus_map_pkg::REG_LEDS:        leds_reg_o     <= wr_dat_i;
            bus_map_pkg::REG_CGEN_CTRL:   cgen_reg_o     <= wr_dat_i;
            bus_map_pkg::REG_TEST:        test_reg_o     <= wr_dat_i;
            bus_map_pkg::REG_TX_FRAMELEN: tx_frame_len_o <= wr_dat_i;
            bus_map_pkg::REG_XFER_RATE:
            begin
               // Only the enables and the rate byte are kept
               rate_o  <= wr_dat_i[RATE_W-1:0];
               tx_en_o <= wr_dat_i[bus_map_pkg::TX_EN_BIT];
               rx_en_o <= wr_dat_i[bus_map_pkg::RX_EN_BIT];
            end
            default: ;   // Read-only and unmapped offsets
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Board lines
   // LEDs are wired out of order on the board
   assign led_o = {leds_reg_o[0], leds_reg_o[2], leds_reg_o[1]};

   assign cgen_sync_b_o  = cgen_reg_o[1];   // Active low sync
   assign cgen_ref_sel_o = cgen_reg_o[0];

endmodule

`default_nettype wire

// ==== source/read_result_mux.sv ====
// Slave 0 read data select and single-cycle acknowledge
`timescale 1ns/1ps
`default_nettype none

module read_result_mux
#(
   parameter int DATA_W = bus_map_pkg::DATA_W
)
(
   input  wire ctrl_kind_pkg::access_e acc_kind_i,
   input  wire logic                   ctrl_hit_i,
   input  wire bus_map_pkg::reg_off_e  reg_off_i,
   input  wire logic [DATA_W-1:0]      leds_reg_i,
   input  wire logic [DATA_W-1:0]      cgen_reg_i,
   input  wire logic [DATA_W-1:0]      test_reg_i,
   input  wire logic [7:0]             dip_sw_i,
   input  wire logic [2:0]             push_btn_i,
   input  wire logic                   cgen_st_status_i,
   input  wire logic                   cgen_st_ld_i,
   input  wire logic                   cgen_st_refmon_i,
   input  wire logic [DATA_W-1:0]      rx_frame_len_i,
   output logic [DATA_W-1:0]           wb_dat_o,
   output logic                        wb_ack_o
);

   // Ack in the same cycle, so every slave 0 access is one cycle long
   assign wb_ack_o = ctrl_hit_i && (acc_kind_i != ctrl_kind_pkg::ACC_IDLE);

   always_comb
   begin
      case (reg_off_i)
         bus_map_pkg::REG_LEDS:      wb_dat_o = leds_reg_i;
         bus_map_pkg::REG_SWITCHES:  wb_dat_o = {{(DATA_W-11){1'b0}}, push_btn_i, dip_sw_i};
         bus_map_pkg::REG_CGEN_CTRL: wb_dat_o = cgen_reg_i;
         bus_map_pkg::REG_CGEN_ST:
         begin
            wb_dat_o = {{(DATA_W-3){1'b0}}, cgen_st_status_i, cgen_st_ld_i,
                        cgen_st_refmon_i};
         end
         bus_map_pkg::REG_TEST:        wb_dat_o = test_reg_i;
         bus_map_pkg::REG_RX_FRAMELEN: wb_dat_o = rx_frame_len_i;
         // TX frame length and rate fall through here as well
         default: wb_dat_o = DATA_W'(bus_map_pkg::READ_FILLER);
      endcase
   end

endmodule

`default_nettype wire

// ==== source/wb_slave_decode.sv ====
// Wishbone cycle decoder, classifies the access and picks out slave 0 and its offset
`timescale 1ns/1ps
`default_nettype none

module wb_slave_decode
#(
   parameter int ADDR_W = bus_map_pkg::ADDR_W
)
(
   input  wire logic              wb_cyc_i,
   input  wire logic              wb_stb_i,
   input  wire logic              wb_we_i,
   input  wire logic [ADDR_W-1:0] wb_adr_i,
   output ctrl_kind_pkg::access_e acc_kind_o,
   output logic                   ctrl_hit_o,
   output bus_map_pkg::reg_off_e  reg_off_o
);

   logic                            live;
   logic [bus_map_pkg::SLAVE_W-1:0] slave_idx;

   assign live      = wb_cyc_i & wb_stb_i;   // Master holds this until ack
   assign slave_idx = wb_adr_i[bus_map_pkg::SLAVE_LSB +: bus_map_pkg::SLAVE_W];

   always_comb
   begin
      if (!live)
         acc_kind_o = ctrl_kind_pkg::ACC_IDLE;
      else if (wb_we_i)
         acc_kind_o = ctrl_kind_pkg::ACC_WRITE;
      else
         acc_kind_o = ctrl_kind_pkg::ACC_READ;
   end

   // Other fifteen slaves are absent, so only index 0 can hit
   assign ctrl_hit_o = live && (slave_idx == bus_map_pkg::CTRL_SLAVE);

   // Offset may name an unmapped register, bank and mux fall to default
   assign reg_off_o = bus_map_pkg::reg_off_e'(wb_adr_i[bus_map_pkg::SLAVE_LSB-1:0]);

endmodule

`default_nettype wire

// ==== source/xfer_pacer.sv ====
// Rate pacer for one ready/ready handshake, grants a slot every rate+1 cycles and flags slips
`timescale 1ns/1ps
`default_nettype none

module xfer_pacer
#(
   parameter int RATE_W = ctrl_kind_pkg::RATE_W
)
(
   input  wire logic              wb_clk,
   input  wire logic              wb_rst,
   input  wire logic              enable_i,
   input  wire logic [RATE_W-1:0] rate_i,
   input  wire logic              up_rdy_i,
   output logic                   up_take_o,
   output logic                   dn_rdy_o,
   input  wire logic              dn_take_i,
   output logic                   slip_o
);

   ctrl_kind_pkg::pacer_state_e state_q;
   logic [RATE_W-1:0]           cnt_q;
   logic                        granted;
   logic                        slot_due;
   logic                        xfer;

   assign granted  = (state_q == ctrl_kind_pkg::PACE_HOLD);
   assign slot_due = (cnt_q == '0);   // Only looked at while counting
   assign xfer     = granted && up_rdy_i && dn_take_i;   // Consumes the slot

   // Handshake passes only through a granted slot
   assign dn_rdy_o  = granted & up_rdy_i;
   assign up_take_o = granted & dn_take_i;

   ////////////////////////////////////////////////////////////////////////////
   // Slot machine
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst || !enable_i)
      begin
         state_q <= ctrl_kind_pkg::PACE_OFF;
         cnt_q   <= '0;
         slip_o  <= 1'b0;
      end
      else
      begin
         slip_o <= 1'b0;
         case (state_q)
            ctrl_kind_pkg::PACE_OFF:
            begin
               cnt_q   <= rate_i;   // First slot rate+1 cycles on
               state_q <= ctrl_kind_pkg::PACE_WAIT;
            end
            ctrl_kind_pkg::PACE_WAIT:
            begin
               if (slot_due)
               begin
                  cnt_q   <= rate_i;
                  state_q <= ctrl_kind_pkg::PACE_HOLD;
               end
               else
                  cnt_q <= cnt_q - 1'b1;
            end
            ctrl_kind_pkg::PACE_HOLD:
            begin
               if (slot_due)
               begin
                  cnt_q  <= rate_i;
                  slip_o <= !xfer;   // Unused slot carries over, still only one held
               end
               else
               begin
                  cnt_q <= cnt_q - 1'b1;
                  if (xfer)
                     state_q <= ctrl_kind_pkg::PACE_WAIT;
               end
            end
            default: state_q <= ctrl_kind_pkg::PACE_OFF;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== tests/ctrl_checker.sv ====
// Testbench checker, watches the control core ports and compares them against a register map model
`timescale 1ns/1ps
`default_nettype none

module ctrl_checker
(
   input wire logic        wb_clk,
   input wire logic        wb_rst,
   input wire logic        cyc_i,
   input wire logic        stb_i,
   input wire logic        we_i,
   input wire logic [10:0] adr_i,
   input wire logic [15:0] wr_dat_i,
   input wire logic [15:0] rd_dat_i,
   input wire logic        ack_i,
   input wire logic [2:0]  led_i,
   input wire logic        sync_b_i,
   input wire logic        ref_sel_i,
   input wire logic [15:0] tx_len_i,
   input wire logic [7:0]  dip_sw_i,
   input wire logic [2:0]  push_btn_i,
   input wire logic [2:0]  cgen_st_i,
   input wire logic [15:0] rx_len_i,
   input wire logic        tx_dn_rdy_i,
   input wire logic        tx_up_take_i,
   input wire logic        tx_slip_i,
   input wire logic        rx_dn_rdy_i,
   input wire logic        rx_up_take_i,
   input wire logic        rx_slip_i
);

   localparam int IDLE  = 0;   // Pacer disabled
   localparam int FLOW  = 1;   // Source and sink always ready
   localparam int STALL = 2;   // One side stuck

   string       test_name = "startup";
   int          checks, errors, tests, failed_tests, test_err_start;
   logic [15:0] m_leds, m_cgen, m_test, m_txlen;
   int          tx_xfers, tx_grants, tx_slips, rx_xfers, rx_grants, rx_slips;
   logic        window, live, hit;

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   // Expected slave 0 read data, from the register map and the board inputs
   function automatic logic [15:0] expect_read(input logic [6:0] off);
      case (off)
         7'd0:    return m_leds;
         7'd2:    return {5'd0, push_btn_i, dip_sw_i};   // Buttons above switches
         7'd4:    return m_cgen;
         7'd6:    return {13'd0, cgen_st_i};
         7'd8:    return m_test;
         7'd10:   return rx_len_i;
         default: return 16'hBEEF;   // Write-only and unmapped
      endcase
   endfunction

   // Slots granted in n cycles, one every rate+1
   function automatic int slot_count(input int n, input int rate);
      return n / (rate + 1);
   endfunction

   task automatic compare(input string what, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic compare_near(input string what, input int exp, input int act);
      checks++;
      if (act < exp - 1 || act > exp + 1)
      begin
         errors++;
         $display("MISMATCH %s %s: expected %0d (+/-1), actual %0d", test_name, what, exp, act);
      end
   endtask

   task automatic note_failure(input string msg);
      errors++;
      $display("ERROR in %s: %s", test_name, msg);
   endtask

   task automatic begin_test(input string name);
      test_name      = name;
      test_err_start = errors;
   endtask

   task automatic end_test();
      tests++;
      if (errors != test_err_start)
         failed_tests++;
      $display("Test %-16s %s, %0d errors", test_name,
               (errors == test_err_start) ? "ok" : "FAIL", errors - test_err_start);
   endtask

   task automatic open_window();
      tx_xfers  = 0;
      tx_grants = 0;
      tx_slips  = 0;
      rx_xfers  = 0;
      rx_grants = 0;
      rx_slips  = 0;
      window    = 1'b1;
   endtask

   task automatic check_pacing(input logic rx_side, input int mode, input int rate, input int n);
      int    xfers;
      int    grants;
      int    slips;
      string side;
      window = 1'b0;
      side   = rx_side ? "rx" : "tx";
      xfers  = rx_side ? rx_xfers : tx_xfers;
      grants = rx_side ? rx_grants : tx_grants;
      slips  = rx_side ? rx_slips : tx_slips;
      case (mode)
         IDLE:
         begin
            compare({side, " grants"}, 16'd0, 16'(grants));
            compare({side, " slips"}, 16'd0, 16'(slips));
         end
         FLOW:
         begin
            compare_near({side, " transfers"}, slot_count(n, rate), xfers);
            compare({side, " slips"}, 16'd0, 16'(slips));
         end
         default:
         begin
            compare({side, " transfers"}, 16'd0, 16'(xfers));
            compare_near({side, " slips"}, slot_count(n, rate) - 1, slips);   // None for first slot
         end
      endcase
   endtask

   task automatic report();
      $display("Tests %0d, failing %0d, checks %0d, errors %0d", tests, failed_tests, checks, errors);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Comparing process, sees pre-edge values at every rising edge
   always @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         m_leds  = 16'd0;
         m_cgen  = 16'd3;
         m_test  = 16'd0;
         m_txlen = 16'd0;
      end
      else
      begin
         live = cyc_i & stb_i;
         hit  = live && (adr_i[10:7] == 4'd0);
         compare("ack", {15'd0, hit}, {15'd0, ack_i});
         if (hit && !we_i)
            compare($sformatf("read offset %0d", adr_i[6:0]), expect_read(adr_i[6:0]), rd_dat_i);
         compare("led_o", {13'd0, m_leds[0], m_leds[2], m_leds[1]}, {13'd0, led_i});
         compare("cgen lines", {14'd0, m_cgen[1:0]}, {14'd0, sync_b_i, ref_sel_i});
         compare("tx_frame_len_o", m_txlen, tx_len_i);
         if (hit && we_i)
         begin
            case (adr_i[6:0])
               7'd0:    m_leds  = wr_dat_i;
               7'd4:    m_cgen  = wr_dat_i;
               7'd8:    m_test  = wr_dat_i;
               7'd12:   m_txlen = wr_dat_i;
               default: ;
            endcase
         end
         if (window)
         begin
            // A transfer shows as both directions open in the same cycle
            tx_xfers  += int'(tx_dn_rdy_i && tx_up_take_i);
            tx_grants += int'(tx_dn_rdy_i || tx_up_take_i);
            tx_slips  += int'(tx_slip_i);
            rx_xfers  += int'(rx_dn_rdy_i && rx_up_take_i);
            rx_grants += int'(rx_dn_rdy_i || rx_up_take_i);
            rx_slips  += int'(rx_slip_i);
         end
      end
   end

endmodule

`default_nettype wire

// ==== tests/tb_ctrl_core.sv ====
// Testbench top for the control core, runs Wishbone accesses and pacer handshakes
`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_core;

   localparam int RESET_CYCLES = 8;
   localparam int PACE_CYCLES  = 120;
   // Two cycles per access, abandoned cycles wait 16
   localparam int BUS_CYCLES   = 2 * (5 + 8 * 7 + 6 * 10 + 4 * 2) + 4 * 2 * 17;
   localparam int PACE_TOTAL   = 20 + 4 * (PACE_CYCLES + 8) + 30;
   localparam int BUDGET       = RESET_CYCLES + BUS_CYCLES + PACE_TOTAL + 200;

   logic        wb_clk;
   logic        wb_rst;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [10:0] wb_adr;
   logic [15:0] wb_wdat;
   logic [15:0] wb_rdat;
   logic        wb_ack;
   logic [2:0]  led;
   logic        cgen_sync_b;
   logic        cgen_ref_sel;
   logic [7:0]  dip_sw;
   logic [2:0]  push_btn;
   logic [2:0]  cgen_st;           // Status, lock, ref monitor
   logic [15:0] rx_len;
   logic [15:0] tx_len;
   logic [3:0]  hs;                // tx src, tx dst, rx src, rx dst
   logic        tx_dn_rdy, tx_up_take, tx_slip;
   logic        rx_dn_rdy, rx_up_take, rx_slip;
   integer      seed;
   int          k;
   logic [3:0]  slave;

   ctrl_core_top dut
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
      .wb_adr_i(wb_adr), .wb_dat_i(wb_wdat), .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack),
      .led_o(led), .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel),
      .dip_sw_i(dip_sw), .push_btn_i(push_btn), .cgen_st_status_i(cgen_st[2]),
      .cgen_st_ld_i(cgen_st[1]), .cgen_st_refmon_i(cgen_st[0]),
      .rx_frame_len_i(rx_len), .tx_frame_len_o(tx_len),
      .tx_src_rdy_i(hs[3]), .tx_dst_rdy_o(tx_up_take), .tx_src_rdy_o(tx_dn_rdy),
      .tx_dst_rdy_i(hs[2]), .tx_underrun_o(tx_slip),
      .rx_src_rdy_i(hs[1]), .rx_dst_rdy_o(rx_up_take), .rx_src_rdy_o(rx_dn_rdy),
      .rx_dst_rdy_i(hs[0]), .rx_overrun_o(rx_slip));

   ctrl_checker chk
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .cyc_i(wb_cyc), .stb_i(wb_stb), .we_i(wb_we),
      .adr_i(wb_adr), .wr_dat_i(wb_wdat), .rd_dat_i(wb_rdat), .ack_i(wb_ack),
      .led_i(led), .sync_b_i(cgen_sync_b), .ref_sel_i(cgen_ref_sel), .tx_len_i(tx_len),
      .dip_sw_i(dip_sw), .push_btn_i(push_btn), .cgen_st_i(cgen_st), .rx_len_i(rx_len),
      .tx_dn_rdy_i(tx_dn_rdy), .tx_up_take_i(tx_up_take), .tx_slip_i(tx_slip),
      .rx_dn_rdy_i(rx_dn_rdy), .rx_up_take_i(rx_up_take), .rx_slip_i(rx_slip));

   initial
   begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus tasks, inputs change on the falling edge only
   task automatic bus_cycle(input logic we, input logic [10:0] adr, input logic [15:0] dat,
                            input logic want_ack);
      int waited;
      @(negedge wb_clk);
      wb_cyc  = 1'b1;
      wb_stb  = 1'b1;
      wb_we   = we;
      wb_adr  = adr;
      wb_wdat = dat;
      waited  = 0;
      do
      begin
         @(posedge wb_clk);
         waited++;
      end
      while (!wb_ack && waited < 16);   // Other slaves never answer
      if (want_ack && !wb_ack)
         chk.note_failure($sformatf("no acknowledge for address %h within 16 cycles", adr));
      @(negedge wb_clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_reg(input logic [6:0] off, input logic [15:0] dat);
      bus_cycle(1'b1, {4'd0, off}, dat, 1'b1);
   endtask

   task automatic read_reg(input logic [6:0] off);
      bus_cycle(1'b0, {4'd0, off}, 16'd0, 1'b1);
   endtask

   // Enables one pacer at a random rate and measures one window
   task automatic run_pacing(input string name, input logic [15:0] en_bits,
                             input logic [3:0] hs_val, input int tx_mode, input int rx_mode);
      int rate;
      rate = 1 + ($random(seed) & 7);
      chk.begin_test(name);
      hs = hs_val;
      write_reg(7'd14, en_bits | 16'(rate));
      chk.open_window();
      repeat (PACE_CYCLES) @(negedge wb_clk);
      chk.check_pacing(1'b0, tx_mode, rate, PACE_CYCLES);
      chk.check_pacing(1'b1, rx_mode, rate, PACE_CYCLES);
      write_reg(7'd14, 16'd0);
      chk.end_test();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   initial
   begin
      seed     = 32'hd4f9;
      wb_rst   = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_wdat  = '0;
      dip_sw   = '0;
      push_btn = '0;
      cgen_st  = '0;
      rx_len   = '0;
      hs       = '0;
      repeat (RESET_CYCLES) @(negedge wb_clk);
      wb_rst = 1'b0;

      chk.begin_test("reset values");
      read_reg(7'd0);
      read_reg(7'd4);
      read_reg(7'd8);
      read_reg(7'd12);
      read_reg(7'd14);
      hs = 4'b1111;
      chk.open_window();
      repeat (20) @(negedge wb_clk);
      chk.check_pacing(1'b0, 0, 0, 20);
      chk.check_pacing(1'b1, 0, 0, 20);
      hs = 4'b0000;
      chk.end_test();

      chk.begin_test("write read-back");
      for (k = 0; k < 8; k++)
      begin
         write_reg(7'd0, 16'($random(seed)));
         write_reg(7'd4, 16'($random(seed)));
         write_reg(7'd8, 16'($random(seed)));
         write_reg(7'd12, 16'($random(seed)));
         read_reg(7'd0);
         read_reg(7'd4);
         read_reg(7'd8);
      end
      chk.end_test();

      chk.begin_test("read-only offsets");
      for (k = 0; k < 6; k++)
      begin
         dip_sw   = 8'($random(seed));
         push_btn = 3'($random(seed));
         cgen_st  = 3'($random(seed));
         rx_len   = 16'($random(seed));
         read_reg(7'd2);
         read_reg(7'd6);
         read_reg(7'd10);
         write_reg(7'd2, 16'($random(seed)));
         write_reg(7'd6, 16'($random(seed)));
         write_reg(7'd10, 16'($random(seed)));
         read_reg(7'($random(seed)) | 7'h10);   // Past the last register
         read_reg(7'd0);
         read_reg(7'd4);
         read_reg(7'd8);
      end
      chk.end_test();

      chk.begin_test("other slaves");
      for (k = 0; k < 4; k++)
      begin
         slave = 4'($random(seed));
         if (slave == 4'd0)
            slave = 4'd9;
         bus_cycle(1'b1, {slave, 7'd0}, 16'($random(seed)), 1'b0);
         bus_cycle(1'b1, {slave, 7'd8}, 16'($random(seed)), 1'b0);
         read_reg(7'd0);
         read_reg(7'd8);
      end
      chk.end_test();

      run_pacing("tx pacing", 16'h8000, 4'b1111, 1, 0);
      run_pacing("rx pacing", 16'h4000, 4'b1111, 0, 1);
      run_pacing("tx underrun", 16'h8000, 4'b0111, 2, 0);
      run_pacing("rx overrun", 16'h4000, 4'b1110, 0, 2);

      chk.report();
      if (chk.errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   // Watchdog
   initial
   begin
      repeat (BUDGET) @(posedge wb_clk);
      $display("Timeout, tests still running after %0d cycles", BUDGET);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/bus_map_pkg.sv
source/ctrl_kind_pkg.sv
source/wb_slave_decode.sv
source/ctrl_reg_bank.sv
source/read_result_mux.sv
source/xfer_pacer.sv
source/ctrl_core_top.sv
tests/ctrl_checker.sv
tests/tb_ctrl_core.sv
